/* flist.f */
+incdir+test
rtl/nnPkg.sv
rtl/neuron.sv
rtl/denseLayer.sv
rtl/argMax.sv
rtl/mlpTop.sv
test/mlpTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mlpTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT = Finished with no errors

SOURCES = $(wildcard rtl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/mlpRef.svh */
`ifndef MLP_REF_SVH
`define MLP_REF_SVH

typedef dataT [numInputs-1:0] featureVecT;
typedef actT [numHidden-1:0] hiddenVecT;
typedef actT [numClasses-1:0] scoreVecT;

// negative sums give 0, sums above satLimit give 255, the rest give bits 12 to 5
function automatic actT refActivate(input dataT sum);
	if (sum[23])
		return 8'd0;
	if (int'(sum) > satLimit)
		return 8'd255;
	return sum[12:5];
endfunction

function automatic hiddenVecT refHiddenLayer(input featureVecT x);
	hiddenVecT a;
	longint acc;
	for (int n = 0; n < numHidden; n++)
	begin
		acc = longint'(hiddenBias[n]);
		for (int i = 0; i < numInputs; i++)
			acc += longint'(x[i]) * longint'(hiddenWeights[n][i]);
		a[n] = refActivate(dataT'(acc[23:0]));   // keep the low 24 bits only
	end
	return a;
endfunction

function automatic scoreVecT refOutLayer(input hiddenVecT h);
	scoreVecT s;
	longint acc;
	for (int c = 0; c < numClasses; c++)
	begin
		acc = longint'(outBias[c]);
		for (int i = 0; i < numHidden; i++)
			acc += longint'({24'd0, h[i]}) * longint'(outWeights[c][i]);   // activations are unsigned
		s[c] = refActivate(dataT'(acc[23:0]));
	end
	return s;
endfunction

function automatic resultT refClassify(input featureVecT x);
	resultT r;
	actT best;
	r.scores = refOutLayer(refHiddenLayer(x));
	best = '0;
	for (int c = 0; c < numClasses; c++)
		if (r.scores[c] > best)
			best = r.scores[c];
	// walk down so the lowest index holding the top score wins
	for (int c = numClasses - 1; c >= 0; c--)
		if (r.scores[c] == best)
			r.classIdx = classIdxT'(c);
	r.valid = 1'b1;
	return r;
endfunction

`endif

/* test/mlpTb.sv */
module mlpTb import nnPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	`include "mlpRef.svh"

	localparam int clkPeriod = 8;
	localparam int resetCycles = 16;
	localparam int latency = 7;
	localparam int streamCount = 200;
	localparam int bubbleCount = 60;
	localparam int tieTries = 4000;
	localparam int totalVectors = 1 + streamCount + 4 + 1 + bubbleCount;
	localparam int cycleLimit = 20 * totalVectors + 200;

	typedef struct
	{
		resultT res;
		int due;   // cycle at which the result must show up
	} expectT;

	logic clk;
	logic reset;
	logic inValid;
	featureVecT features;
	resultT result;

	expectT expQ[$];
	resultT headRes = '0;
	int headDue = -1;
	int queueDepth = 0;
	int cycleCount = 0;
	bit firstSeen = 1'b0;
	int errorCount = 0;
	int testCount = 0;
	string testName = "reset";
	logic [15:0] lfsrState = 16'd47;

	mlpTop i_dut
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.features(features),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic featureVecT randomVector();
		featureVecT v;
		logic [8:0] b;
		for (int i = 0; i < numInputs; i++)
		begin
			b = randomBits(9);
			v[i] = {{15{b[8]}}, b};   // 9 bits, sign extended
		end
		return v;
	endfunction

	function automatic bit hasTie(input resultT r);
		int hits;
		hits = 0;
		for (int c = 0; c < numClasses; c++)
			if (r.scores[c] == r.scores[r.classIdx])
				hits++;
		return hits > 1;
	endfunction

	task automatic sendVector(input featureVecT v);
		@(posedge clk);
		inValid <= 1'b1;
		features <= v;
	endtask

	task automatic idleCycle();
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	task automatic drain();
		idleCycle();
		@(posedge clk);
		while (expQ.size() > 0)
			@(posedge clk);
		repeat (2) @(posedge clk);   // let the last checks settle
	endtask

	task automatic reportTest(input int errorsBefore, input int vectors);
		testCount++;
		$display("test %s: %0d vectors, %0d errors", testName, vectors, errorCount - errorsBefore);
	endtask

	// expected results, in input order
	always @(posedge clk)
	begin
		expectT e;
		cycleCount <= cycleCount + 1;
		if (result.valid)
		begin
			firstSeen <= 1'b1;
			if (expQ.size() > 0)
				void'(expQ.pop_front());
		end
		if (!reset && inValid)
		begin
			e.res = refClassify(features);
			e.due = cycleCount + latency;
			expQ.push_back(e);
		end
		queueDepth <= expQ.size();
		headRes <= (expQ.size() > 0) ? expQ[0].res : '0;
		headDue <= (expQ.size() > 0) ? expQ[0].due : -1;
	end

	resultCheck: assert property (@(posedge clk) disable iff (reset)
		(result.valid && queueDepth > 0) |-> result == headRes)
		else
		begin
			errorCount++;
			$display("** Error %s: result expected %h actual %h", testName,
				$sampled(headRes), $sampled(result));
		end

	latencyCheck: assert property (@(posedge clk) disable iff (reset)
		(result.valid && queueDepth > 0) |-> cycleCount == headDue)
		else
		begin
			errorCount++;
			$display("** Error %s: result cycle expected %0d actual %0d", testName,
				$sampled(headDue), $sampled(cycleCount));
		end

	extraCheck: assert property (@(posedge clk) disable iff (reset)
		result.valid |-> queueDepth > 0)
		else
		begin
			errorCount++;
			$display("%s: a result appeared with no vector outstanding", testName);
		end

	resetCheck: assert property (@(posedge clk)
		(cycleCount > 0 && $past(reset)) |-> result == '0)
		else
		begin
			errorCount++;
			$display("%s: result is not cleared by reset", testName);
		end

	idleCheck: assert property (@(posedge clk)
		(cycleCount > 0 && !firstSeen && !result.valid) |-> result == '0)
		else
		begin
			errorCount++;
			$display("%s: result fields changed before the first vector arrived", testName);
		end

	initial
	begin
		while (cycleCount < cycleLimit)
			@(posedge clk);
		$display("timeout after %0d cycles, %0d results never arrived", cycleLimit, expQ.size());
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		featureVecT v;
		int errorsBefore;
		int sent;
		bit tieFound;
		reset = 1'b1;
		inValid = 1'b0;
		features = '0;

		errorsBefore = errorCount;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
		repeat (8) @(posedge clk);   // nothing sent, output must stay quiet
		reportTest(errorsBefore, 0);

		testName = "latency";
		errorsBefore = errorCount;
		sendVector(randomVector());
		drain();
		reportTest(errorsBefore, 1);

		testName = "streaming";
		errorsBefore = errorCount;
		for (int n = 0; n < streamCount; n++)
			sendVector(randomVector());
		drain();
		reportTest(errorsBefore, streamCount);

		testName = "extremes";
		errorsBefore = errorCount;
		sendVector({numInputs{dataT'(1000)}});
		sendVector({numInputs{dataT'(-1000)}});
		sendVector('0);   // scores come from the biases alone
		sendVector({numInputs{dataT'(24'h5A5A5A)}});   // products overflow 24 bits and wrap
		drain();
		reportTest(errorsBefore, 4);

		testName = "ties and bubbles";
		errorsBefore = errorCount;
		tieFound = 1'b0;
		for (int t = 0; t < tieTries && !tieFound; t++)
		begin
			v = randomVector();
			tieFound = hasTie(refClassify(v));
		end
		if (tieFound)
			sendVector(v);
		else
		begin
			errorCount++;
			$display("%s: no vector with tied scores was found", testName);
		end
		sent = 0;
		while (sent < bubbleCount)
		begin
			if (randomBits(1) == 1)
			begin
				sendVector(randomVector());
				sent++;
			end
			else
				idleCycle();
		end
		drain();
		reportTest(errorsBefore, bubbleCount + 1);

		$display("tests: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* rtl/mlpTop.sv */
module mlpTop import nnPkg::*;
#(
	parameter dataT [0:numHidden-1][0:numInputs-1] hiddenW = hiddenWeights,
	parameter dataT [0:numHidden-1] hiddenB = hiddenBias,
	parameter dataT [0:numClasses-1][0:numHidden-1] outW = outWeights,
	parameter dataT [0:numClasses-1] outB = outBias
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input dataT [numInputs-1:0] features,
	output resultT result
);

	localparam int padBits = $bits(dataT) - $bits(actT);

	actT [numHidden-1:0] hiddenAct;
	logic hiddenValid;
	dataT [numHidden-1:0] hiddenExt;   // activations widened for the next layer
	actT [numClasses-1:0] outAct;
	logic outValid;

	denseLayer
	#(
		.numIn(numInputs),
		.numOut(numHidden),
		.weights(hiddenW),
		.bias(hiddenB)
	)
	hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.in(features),
		.outValid(hiddenValid),
		.act(hiddenAct)
	);

	always_comb
	begin
		for (int i = 0; i < numHidden; i++)
		begin
			hiddenExt[i] = {{padBits{1'b0}}, hiddenAct[i]};   // unsigned, zero fill
		end
	end

	denseLayer
	#(
		.numIn(numHidden),
		.numOut(numClasses),
		.weights(outW),
		.bias(outB)
	)
	outLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.in(hiddenExt),
		.outValid(outValid),
		.act(outAct)
	);

	argMax
	#(
		.numIn(numClasses)
	)
	picker
	(
		.clk(clk),
		.reset(reset),
		.inValid(outValid),
		.scores(outAct),
		.result(result)
	);

endmodule

/* rtl/argMax.sv */
module argMax import nnPkg::*;
#(
	parameter int numIn = numClasses
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input actT [numIn-1:0] scores,
	output resultT result
);

	classIdxT bestIdx;
	actT bestScore;

	if (numIn != numClasses || numIn > 2 ** $bits(classIdxT))
	begin : gSizeCheck
		$error("argMax: numIn does not fit resultT");
	end

	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[0];
		for (int i = 1; i < numIn; i++)
		begin
			if (scores[i] > bestScore)   // strict, so ties keep the lower index
			begin
				bestIdx = classIdxT'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else
		begin
			result.valid <= inValid;
			if (inValid)
			begin
				result.classIdx <= bestIdx;
				result.scores <= scores;
			end
		end
	end

	idxCheck: assert property (@(posedge clk) disable iff (reset)
		result.valid |-> result.classIdx < numIn)
		else $error("argMax: class index out of range");

endmodule

/* rtl/denseLayer.sv */
module denseLayer import nnPkg::*;
#(
	parameter int numIn = numInputs,
	parameter int numOut = numHidden,
	parameter dataT [0:numOut-1][0:numIn-1] weights = '0,
	parameter dataT [0:numOut-1] bias = '0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input dataT [numIn-1:0] in,
	output logic outValid,
	output actT [numOut-1:0] act
);

	localparam int depth = 3;   // neuron latency

	logic [depth-1:0] validPipe;

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[depth-2:0], inValid};
	end

	assign outValid = validPipe[depth-1];

	for (genvar n = 0; n < numOut; n++)
	begin : gNeuron
		neuron
		#(
			.numIn(numIn),
			.weights(weights[n]),
			.bias(bias[n])
		)
		unit
		(
			.clk(clk),
			.reset(reset),
			.in(in),
			.act(act[n])
		);
	end

	// only checked once the pipe has been clear of reset for a full latency
	alignCheck: assert property (@(posedge clk)
		(!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
			|-> outValid == $past(inValid, depth))
		else $error("denseLayer: valid out of step with neuron pipeline");

endmodule

/* rtl/neuron.sv */
module neuron import nnPkg::*;
#(
	parameter int numIn = numInputs,
	parameter dataT [0:numIn-1] weights = '0,
	parameter dataT bias = '0
)
(
	input logic clk,
	input logic reset,
	input dataT [numIn-1:0] in,
	output actT act
);

	localparam int signBit = $bits(dataT) - 1;

	dataT [numIn-1:0] inReg;   // stage 1
	dataT sumReg;              // stage 2

	// products and the running sum wrap at 24 bits
	function automatic dataT weightedSum(input dataT [numIn-1:0] x);
		dataT acc;
		acc = bias;
		for (int i = 0; i < numIn; i++)
		begin
			acc = acc + dataT'(x[i] * weights[i]);
		end
		return acc;
	endfunction

	function automatic actT activate(input dataT sum);
		actT a;
		if (sum[signBit])
			a = '0;            // negative clamps to zero
		else if (sum > satLimit)
			a = '1;            // saturate
		else
			a = sum[12:5];
		return a;
	endfunction

	always_ff @(posedge clk)
	begin
		inReg <= in;
		sumReg <= weightedSum(inReg);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			act <= '0;
		else
			act <= activate(sumReg);
	end

	satCheck: assert property (@(posedge clk) disable iff (reset)
		(!sumReg[signBit] && sumReg > satLimit) |=> act == 8'hFF)
		else $error("neuron: large positive sum did not saturate");

endmodule

/* rtl/nnPkg.sv */
package nnPkg;

	typedef logic signed [23:0] dataT;   // signed fixed-point word
	typedef logic [7:0] actT;            // activation output
	typedef logic [1:0] classIdxT;

	localparam int numInputs = 15;
	localparam int numHidden = 4;
	localparam int numClasses = 3;
	localparam int satLimit = 4096;   // sums above this give 255

	typedef struct packed
	{
		logic valid;
		classIdxT classIdx;
		actT [numClasses-1:0] scores;
	} resultT;

	// one row per hidden neuron, row 0 first
	localparam dataT [0:numHidden-1][0:numInputs-1] hiddenWeights = '{
		'{
			-4, 7, 13, 6, 2,
			25, 11, -12, -23, -22,
			6, -17, 17, -12, -8
		},
		'{
			9, -3, 21, -15, 4,
			-7, 18, 2, -11, 14,
			-19, 5, 8, 23, -6
		},
		'{
			-13, 16, -2, 10, -21,
			12, -5, 19, 3, -9,
			24, -14, 1, -18, 15
		},
		'{
			20, -10, 6, -24, 11,
			-1, -16, 22, 7, -20,
			3, 13, -8, 9, 17
		}
	};

	localparam dataT [0:numHidden-1] hiddenBias = '{3, -40, 128, 64};

	// inputs here are hidden activations, 0 to 255
	localparam dataT [0:numClasses-1][0:numHidden-1] outWeights = '{
		'{12, -7, 9, -3},
		'{-5, 14, -6, 11},
		'{8, 3, -12, 10}
	};

	localparam dataT [0:numClasses-1] outBias = '{16, -32, 48};

endpackage
